// ==== rtl/mont_pkg.sv ====
package mont_pkg;

    // width of a, b, m and the result
    localparam int operand_width = 32;

    // radix-4 digits scanned from a
    localparam int digit_count = operand_width / 2;

    // holds C below 2M plus 3B or 3M
    localparam int acc_width = operand_width + 3;

    // digit counter width
    localparam int count_width = $clog2(digit_count);

    // counter value while the final digit is processed
    localparam logic [count_width-1:0] last_index = count_width'(digit_count - 1);

    // controller states
    typedef enum logic [2:0] {
        idle,
        pre_m,
        pre_b,
        add_b,
        add_m,
        reduce
    } mont_state_e;

    // multiple picked from the table, sel_none means nothing requested
    typedef enum logic [2:0] {
        sel_zero,
        sel_b,
        sel_2b,
        sel_3b,
        sel_m,
        sel_2m,
        sel_3m,
        sel_none
    } mult_sel_e;

endpackage

// ==== rtl/mont_ctrl.sv ====
`timescale 1ns/1ps

module mont_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  logic                  last_digit,
    output logic                  capture,
    output mont_pkg::mult_sel_e   pre_sel,
    output logic                  step_b,
    output logic                  step_m,
    output logic                  count_clear,
    output logic                  count_step,
    output logic                  finish
);

    mont_pkg::mont_state_e state;
    mont_pkg::mont_state_e state_next;

    // state register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= mont_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // every state lasts one cycle except idle
    always_comb begin
        state_next = state;
        case (state)
            mont_pkg::idle: begin
                if (start) begin
                    state_next = mont_pkg::pre_m;
                end
            end
            mont_pkg::pre_m: begin
                state_next = mont_pkg::pre_b;
            end
            mont_pkg::pre_b: begin
                state_next = mont_pkg::add_b;
            end
            mont_pkg::add_b: begin
                state_next = mont_pkg::add_m;
            end
            mont_pkg::add_m: begin
                // the last digit leaves the loop
                if (last_digit) begin
                    state_next = mont_pkg::reduce;
                end else begin
                    state_next = mont_pkg::add_b;
                end
            end
            mont_pkg::reduce: begin
                state_next = mont_pkg::idle;
            end
            default: begin
                state_next = mont_pkg::idle;
            end
        endcase
    end

    // precompute routing, 2M+M first, then 2B+B
    always_comb begin
        case (state)
            mont_pkg::pre_m: begin
                pre_sel = mont_pkg::sel_2m;
            end
            mont_pkg::pre_b: begin
                pre_sel = mont_pkg::sel_2b;
            end
            default: begin
                pre_sel = mont_pkg::sel_none;
            end
        endcase
    end

    // start is only honored in idle
    assign capture = (state == mont_pkg::idle) && start;

    assign step_b = (state == mont_pkg::add_b);
    assign step_m = (state == mont_pkg::add_m);

    // counter restarts with each accepted operation
    assign count_clear = capture;

    // one count per completed digit
    assign count_step = step_m;

    assign finish = (state == mont_pkg::reduce);

endmodule

// ==== rtl/digit_counter.sv ====
`timescale 1ns/1ps

module digit_counter (
    input  logic clk,
    input  logic resetn,
    input  logic count_clear,
    input  logic count_step,
    output logic last_digit
);

    // index of the digit in progress
    logic [mont_pkg::count_width-1:0] count;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (count_clear) begin
            count <= '0;
        end else if (count_step) begin
            // wraps back to zero after the final digit
            count <= count + 1'b1;
        end
    end

    // high through the add_b/add_m pair of the final digit
    assign last_digit = (count == mont_pkg::last_index);

endmodule

// ==== rtl/multiple_table.sv ====
`timescale 1ns/1ps

module multiple_table (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                capture,
    input  logic [mont_pkg::operand_width-1:0]  in_b,
    input  logic [mont_pkg::operand_width-1:0]  in_m,
    input  logic                                store_3b,
    input  logic                                store_3m,
    input  logic [mont_pkg::acc_width-1:0]      sum,
    input  mont_pkg::mult_sel_e                 sel,
    output logic [mont_pkg::acc_width-1:0]      multiple,
    output logic [1:0]                          m_low
);

    logic [mont_pkg::operand_width-1:0] b_q;
    logic [mont_pkg::operand_width-1:0] m_q;
    logic [mont_pkg::acc_width-1:0]     b3_q;
    logic [mont_pkg::acc_width-1:0]     m3_q;

    // operands held for the whole operation
    always_ff @(posedge clk) begin
        if (!resetn) begin
            b_q <= '0;
            m_q <= '0;
        end else if (capture) begin
            b_q <= in_b;
            m_q <= in_m;
        end
    end

    // 3B and 3M come back from the shared adder
    always_ff @(posedge clk) begin
        if (!resetn) begin
            b3_q <= '0;
            m3_q <= '0;
        end else begin
            if (store_3b) begin
                b3_q <= sum;
            end
            if (store_3m) begin
                m3_q <= sum;
            end
        end
    end

    // doubles are just wiring
    always_comb begin
        case (sel)
            mont_pkg::sel_b: begin
                multiple = {3'b000, b_q};
            end
            mont_pkg::sel_2b: begin
                multiple = {2'b00, b_q, 1'b0};
            end
            mont_pkg::sel_3b: begin
                multiple = b3_q;
            end
            mont_pkg::sel_m: begin
                multiple = {3'b000, m_q};
            end
            mont_pkg::sel_2m: begin
                multiple = {2'b00, m_q, 1'b0};
            end
            mont_pkg::sel_3m: begin
                multiple = m3_q;
            end
            // sel_zero and sel_none
            default: begin
                multiple = '0;
            end
        endcase
    end

    // quotient digit rule depends on m mod 4
    assign m_low = m_q[1:0];

endmodule

// ==== rtl/mont_accumulator.sv ====
`timescale 1ns/1ps

module mont_accumulator (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                capture,
    input  logic [mont_pkg::operand_width-1:0]  in_a,
    input  mont_pkg::mult_sel_e                 pre_sel,
    input  logic                                step_b,
    input  logic                                step_m,
    input  logic                                finish,
    input  logic [mont_pkg::acc_width-1:0]      multiple,
    input  logic [1:0]                          m_low,
    output mont_pkg::mult_sel_e                 sel,
    output logic [mont_pkg::acc_width-1:0]      sum,
    output logic                                store_3b,
    output logic                                store_3m,
    output logic [mont_pkg::operand_width-1:0]  result,
    output logic                                done
);

    // remaining digits of a, low digit first
    logic [mont_pkg::operand_width-1:0] a_q;
    // accumulator C
    logic [mont_pkg::acc_width-1:0]     c_q;
    logic [mont_pkg::acc_width-1:0]     addend;
    logic [mont_pkg::acc_width:0]       diff;
    logic [1:0]                         quot;
    logic                               precompute;

    assign precompute = (pre_sel != mont_pkg::sel_none);

    // store the sum into the table register being precomputed
    assign store_3m = (pre_sel == mont_pkg::sel_2m);
    assign store_3b = (pre_sel == mont_pkg::sel_2b);

    // during precompute the table gives 2X, so half of it is X
    assign addend = precompute ? (multiple >> 1) : c_q;

    // the single adder
    assign sum = addend + multiple;

    // makes C + quot*M a multiple of 4
    always_comb begin
        if (m_low == 2'b11) begin
            quot = c_q[1:0];
        end else begin
            quot = 2'b00 - c_q[1:0];
        end
    end

    always_comb begin
        sel = mont_pkg::sel_none;
        if (precompute) begin
            sel = pre_sel;
        end else if (step_b) begin
            // current digit of a times B
            case (a_q[1:0])
                2'd0: sel = mont_pkg::sel_zero;
                2'd1: sel = mont_pkg::sel_b;
                2'd2: sel = mont_pkg::sel_2b;
                2'd3: sel = mont_pkg::sel_3b;
            endcase
        end else if (step_m) begin
            case (quot)
                2'd0: sel = mont_pkg::sel_zero;
                2'd1: sel = mont_pkg::sel_m;
                2'd2: sel = mont_pkg::sel_2m;
                2'd3: sel = mont_pkg::sel_3m;
            endcase
        end else if (finish) begin
            // M for the trial subtraction
            sel = mont_pkg::sel_m;
        end
    end

    // a digits and C
    always_ff @(posedge clk) begin
        if (capture) begin
            a_q <= in_a;
            c_q <= '0;
        end else if (step_b) begin
            c_q <= sum;
        end else if (step_m) begin
            // low two bits are zero here
            a_q <= {2'b00, a_q[mont_pkg::operand_width-1:2]};
            c_q <= {2'b00, sum[mont_pkg::acc_width-1:2]};
        end
    end

    // borrow out means C < M
    assign diff = {1'b0, c_q} - {1'b0, multiple};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= finish;
            if (finish) begin
                if (diff[mont_pkg::acc_width]) begin
                    result <= c_q[mont_pkg::operand_width-1:0];
                end else begin
                    result <= diff[mont_pkg::operand_width-1:0];
                end
            end
        end
    end

endmodule

// ==== rtl/montgomery_mult.sv ====
`timescale 1ns/1ps

module montgomery_mult (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                start,
    input  logic [mont_pkg::operand_width-1:0]  in_a,
    input  logic [mont_pkg::operand_width-1:0]  in_b,
    input  logic [mont_pkg::operand_width-1:0]  in_m,
    output logic [mont_pkg::operand_width-1:0]  result,
    output logic                                done
);

    // controller to datapath
    logic                           capture;
    mont_pkg::mult_sel_e            pre_sel;
    logic                           step_b;
    logic                           step_m;
    logic                           finish;

    // controller and counter
    logic                           count_clear;
    logic                           count_step;
    logic                           last_digit;

    // accumulator and table
    mont_pkg::mult_sel_e            sel;
    logic [mont_pkg::acc_width-1:0] sum;
    logic [mont_pkg::acc_width-1:0] multiple;
    logic                           store_3b;
    logic                           store_3m;
    logic [1:0]                     m_low;

    mont_ctrl ctrl_i (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .last_digit  (last_digit),
        .capture     (capture),
        .pre_sel     (pre_sel),
        .step_b      (step_b),
        .step_m      (step_m),
        .count_clear (count_clear),
        .count_step  (count_step),
        .finish      (finish)
    );

    digit_counter counter_i (
        .clk         (clk),
        .resetn      (resetn),
        .count_clear (count_clear),
        .count_step  (count_step),
        .last_digit  (last_digit)
    );

    multiple_table table_i (
        .clk         (clk),
        .resetn      (resetn),
        .capture     (capture),
        .in_b        (in_b),
        .in_m        (in_m),
        .store_3b    (store_3b),
        .store_3m    (store_3m),
        .sum         (sum),
        .sel         (sel),
        .multiple    (multiple),
        .m_low       (m_low)
    );

    mont_accumulator acc_i (
        .clk         (clk),
        .resetn      (resetn),
        .capture     (capture),
        .in_a        (in_a),
        .pre_sel     (pre_sel),
        .step_b      (step_b),
        .step_m      (step_m),
        .finish      (finish),
        .multiple    (multiple),
        .m_low       (m_low),
        .sel         (sel),
        .sum         (sum),
        .store_3b    (store_3b),
        .store_3m    (store_3m),
        .result      (result),
        .done        (done)
    );

endmodule

// ==== bench/montgomery_mult_tb.sv ====
`timescale 1ns/1ps

module montgomery_mult_tb;

    logic                               clk;
    logic                               resetn;
    logic                               start;
    logic [mont_pkg::operand_width-1:0] in_a;
    logic [mont_pkg::operand_width-1:0] in_b;
    logic [mont_pkg::operand_width-1:0] in_m;
    logic [mont_pkg::operand_width-1:0] result;
    logic                               done;

    // stimulus table, one entry per operation
    logic [mont_pkg::operand_width-1:0] tab_a[$];
    logic [mont_pkg::operand_width-1:0] tab_b[$];
    logic [mont_pkg::operand_width-1:0] tab_m[$];
    logic [mont_pkg::operand_width-1:0] tab_exp[$];

    logic [31:0]                        lfsr_state;
    logic [mont_pkg::operand_width-1:0] prev_result;
    int                                 cycle_count;

    montgomery_mult montgomery_mult_i (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("FAIL at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("Test failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic fail_text(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    // bit-serial reference, a*b*2^-N mod m
    function automatic logic [mont_pkg::operand_width-1:0] mont_ref(
        input logic [mont_pkg::operand_width-1:0] a,
        input logic [mont_pkg::operand_width-1:0] b,
        input logic [mont_pkg::operand_width-1:0] m);
        logic [mont_pkg::operand_width+1:0] s;
        s = '0;
        for (int i = 0; i < mont_pkg::operand_width; i++) begin
            if (a[i]) begin
                s = s + b;
            end
            if (s[0]) begin
                s = s + m;
            end
            s = s >> 1;
        end
        if (s >= m) begin
            s = s - m;
        end
        return s[mont_pkg::operand_width-1:0];
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [mont_pkg::operand_width-1:0] random_word();
        logic [mont_pkg::operand_width-1:0] w;
        w = '0;
        for (int i = 0; i < mont_pkg::operand_width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[mont_pkg::operand_width-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic void add_row(input logic [mont_pkg::operand_width-1:0] a,
                                    input logic [mont_pkg::operand_width-1:0] b,
                                    input logic [mont_pkg::operand_width-1:0] m);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_m.push_back(m);
        tab_exp.push_back(mont_ref(a, b, m));
    endfunction

    // one operation, start issued on the first edge after the call
    task automatic run_row(input logic [mont_pkg::operand_width-1:0] a,
                           input logic [mont_pkg::operand_width-1:0] b,
                           input logic [mont_pkg::operand_width-1:0] m,
                           input logic [mont_pkg::operand_width-1:0] exp,
                           input bit disturb);
        int j;
        @(posedge clk);
        start <= 1'b1;
        in_a  <= a;
        in_b  <= b;
        in_m  <= m;
        // done of the previous operation is over, result still held
        @(negedge clk);
        assert (done === 1'b0) else fail_value("done", done, 1'b0);
        assert (result === prev_result) else fail_value("result", result, prev_result);
        @(posedge clk);
        start <= 1'b0;
        j = 0;
        @(negedge clk);
        while (done !== 1'b1 && j <= mont_pkg::operand_width + 10) begin
            @(posedge clk);
            j++;
            if (disturb && j == 4) begin
                // busy start and new operands, both must be ignored
                start <= 1'b1;
                in_a  <= random_word();
                in_b  <= random_word();
                in_m  <= random_word() | 1;
            end
            if (j == 5) begin
                start <= 1'b0;
            end
            @(negedge clk);
        end
        assert (done === 1'b1) else fail_text("done never rose after start");
        assert (j == mont_pkg::operand_width + 3) else
            fail_text($sformatf("done rose %0d cycles after start instead of %0d",
                                j, mont_pkg::operand_width + 3));
        assert (result === exp) else fail_value("result", result, exp);
        prev_result = exp;
    endtask

    initial begin
        int                                 fixed_rows;
        logic [mont_pkg::operand_width-1:0] ra;
        logic [mont_pkg::operand_width-1:0] rb;
        logic [mont_pkg::operand_width-1:0] rm;
        resetn      = 1'b0;
        start       = 1'b0;
        in_a        = '0;
        in_b        = '0;
        in_m        = '0;
        prev_result = '0;
        lfsr_state  = 32'h1e1f19f3;

        // a = b = 1 with m ending in 01 and 11
        add_row(32'd1, 32'd1, 32'd13);
        add_row(32'd1, 32'd1, 32'd15);
        add_row(32'd1, 32'd1, 32'h8000_0001);
        add_row(32'd1, 32'd1, 32'hFFFF_FFFB);
        add_row(32'd0, 32'd12345, 32'h7FFF_FFFF);
        // a = b = m-1
        add_row(32'hF123_4566, 32'hF123_4566, 32'hF123_4567);
        add_row(32'hC000_0004, 32'hC000_0004, 32'hC000_0005);
        add_row(32'hFFFF_FFFE, 32'hFFFF_FFFE, 32'hFFFF_FFFF);
        add_row(32'h1234_5678, 32'h9ABC_DEF0, 32'hFFFF_FFFF);
        // every a digit 0..3, both quotient rules
        add_row(32'hE4E4_E4E4, 32'h0BAD_F00D, 32'hF5A3_9C41);
        add_row(32'h1B1B_1B1B, 32'hCAFE_1234, 32'hFEDC_BA97);
        fixed_rows = tab_a.size();
        for (int k = 0; k < 20; k++) begin
            rm = random_word() | 1;
            ra = random_word() % rm;
            rb = random_word() % rm;
            add_row(ra, rb, rm);
        end

        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (done === 1'b0) else fail_value("done", done, 1'b0);
            assert (result === '0) else fail_value("result", result, '0);
        end

        for (int i = 0; i < tab_a.size(); i++) begin
            run_row(tab_a[i], tab_b[i], tab_m[i], tab_exp[i], i < fixed_rows && i % 2 == 1);
        end

        // last done is one cycle wide and result keeps its value
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            assert (done === 1'b0) else fail_value("done", done, 1'b0);
            assert (result === prev_result) else fail_value("result", result, prev_result);
        end

        $display("Test completed successfully");
        $finish;
    end

    // limit follows the table length
    initial begin
        cycle_count = 0;
        while (cycle_count < tab_a.size() * (mont_pkg::operand_width + 6) + 50) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_count);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

// ==== vlog.f ====
rtl/mont_pkg.sv
rtl/mont_ctrl.sv
rtl/digit_counter.sv
rtl/multiple_table.sv
rtl/mont_accumulator.sv
rtl/montgomery_mult.sv
bench/montgomery_mult_tb.sv
